//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_th_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/qdr_pkg.sv
`default_nettype none

package qdr_pkg;

  localparam int NUM_LANES = 4;

  // One data word that is seen whole or per byte lane
  typedef union packed {
    logic [31:0]                word;
    logic [NUM_LANES-1:0][7:0]  bytes;
  } qdr_word_u;

  typedef struct packed {
    logic        strobe;
    logic [15:0] addr;
    qdr_word_u   data;
  } qdr_wr_t;

  typedef struct packed {
    logic        strobe;
    logic [15:0] addr;
  } qdr_rd_t;

  // One byte lane of a returned word
  typedef struct packed {
    logic        valid;
    logic [15:0] addr;
    logic [7:0]  expected;
    logic [7:0]  actual;
  } lane_cmp_t;

endpackage

`default_nettype wire

//--- rtl/th_lane_check.sv
`timescale 1ns/1ns
`default_nettype none

module th_lane_check
  import qdr_pkg::*;
#(
  parameter int QDR_ADDR_W = 16
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        clear_i,
  input  lane_cmp_t   cmp_i,
  output logic [15:0] err_cnt_o,
  output logic        mismatch_o,
  output logic [15:0] first_addr_o,
  output logic        first_valid_o
);

  logic                  mismatch;
  logic [15:0]           err_cnt_q;
  logic                  mismatch_q;
  logic                  first_valid_q;
  logic [QDR_ADDR_W-1:0] first_addr_q;

  assign mismatch = cmp_i.valid && (cmp_i.expected != cmp_i.actual);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || clear_i) begin
      err_cnt_q     <= '0;
      mismatch_q    <= 1'b0;
      first_valid_q <= 1'b0;
    end else begin
      mismatch_q <= mismatch;
      if (mismatch && err_cnt_q != 16'hffff)  // Saturate
        err_cnt_q <= err_cnt_q + 1'b1;
      if (mismatch)
        first_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (mismatch && !first_valid_q)
      first_addr_q <= cmp_i.addr[QDR_ADDR_W-1:0];
  end

  assign err_cnt_o     = err_cnt_q;
  assign mismatch_o    = mismatch_q;
  assign first_addr_o  = 16'(first_addr_q);
  assign first_valid_o = first_valid_q;

endmodule

`default_nettype wire

//--- rtl/th_regs_pkg.sv
`default_nettype none

package th_regs_pkg;

  // Word addresses taken from wb_adr_i[21:1]
  localparam logic [20:0] REG_CTRL_0        = 21'd0;
  localparam logic [20:0] REG_CTRL_1        = 21'd1;
  localparam logic [20:0] REG_CTRL_2        = 21'd2;
  localparam logic [20:0] REG_CTRL_3        = 21'd3;
  localparam logic [20:0] REG_CTRL_4        = 21'd4;
  localparam logic [20:0] REG_ST_FLAGS      = 21'd16;
  localparam logic [20:0] REG_ST_TOTAL      = 21'd17;
  localparam logic [20:0] REG_ST_LANE_0     = 21'd18;
  localparam logic [20:0] REG_ST_LANE_1     = 21'd19;
  localparam logic [20:0] REG_ST_LANE_2     = 21'd20;
  localparam logic [20:0] REG_ST_LANE_3     = 21'd21;
  localparam logic [20:0] REG_ST_FAIL_ADDR  = 21'd22;
  localparam logic [20:0] REG_ST_FAIL_LANES = 21'd23;

  typedef enum logic [1:0] {
    MODE_ADDR  = 2'd0,  // Address over inverted address
    MODE_WALK1 = 2'd1,
    MODE_LFSR  = 2'd2,
    MODE_CONST = 2'd3   // Seed in both halves
  } th_mode_e;

  // CTRL_4 at the top and CTRL_0 at the bottom
  typedef struct packed {
    logic [11:0] ctrl4_rsvd;
    logic [3:0]  lane_mask;
    logic [15:0] end_addr;    // CTRL_3
    logic [15:0] start_addr;  // CTRL_2
    logic [15:0] seed;        // CTRL_1
    logic [12:0] ctrl0_rsvd;
    th_mode_e    mode;
    logic        start;
  } th_ctrl_t;

  // Bits of REG_ST_FLAGS
  localparam int ST_BUSY_BIT = 0;
  localparam int ST_DONE_BIT = 1;
  localparam int ST_PASS_BIT = 2;

endpackage

`default_nettype wire

//--- rtl/th_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module th_sequencer
  import th_regs_pkg::*;
  import qdr_pkg::*;
#(
  parameter int QDR_ADDR_W = 16,
  parameter int EXP_DEPTH  = 8
) (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  th_ctrl_t                   ctrl_i,
  input  logic                       qdr_rd_valid_i,
  input  qdr_word_u                  qdr_rd_data_i,
  output qdr_wr_t                    qdr_wr_o,
  output qdr_rd_t                    qdr_rd_o,
  output lane_cmp_t [NUM_LANES-1:0]  cmp_o,
  output logic                       busy_o,
  output logic                       run_start_o
);

  localparam int          PTR_W     = (EXP_DEPTH > 1) ? $clog2(EXP_DEPTH) : 1;
  localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WRITE,
    S_READ,
    S_DRAIN,   // All reads issued and waiting for returns
    S_FINISH
  } seq_state_e;

  seq_state_e            state_q;
  logic                  start_q;
  logic                  run_start_q;
  logic                  wr_stb_q;
  logic                  rd_stb_q;
  logic [15:0]           wr_addr_q;
  qdr_word_u             wr_data_q;
  logic [15:0]           rd_addr_q;
  logic [QDR_ADDR_W-1:0] addr_q;
  logic [31:0]           lfsr_q;
  logic [PTR_W:0]        count_q;
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;

  qdr_word_u             exp_data_mem [EXP_DEPTH];
  logic [QDR_ADDR_W-1:0] exp_addr_mem [EXP_DEPTH];

  logic [QDR_ADDR_W-1:0] start_addr;
  logic [QDR_ADDR_W-1:0] end_addr;
  logic                  last_addr;
  logic                  start_edge;
  logic                  rd_issue;
  logic                  pop;
  logic [31:0]           lfsr_seed;
  qdr_word_u             pattern;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? LFSR_POLY : 32'h0);
  endfunction

  function automatic qdr_word_u gen_pattern(input th_mode_e mode, input logic [15:0] addr,
                                            input logic [15:0] seed, input logic [31:0] lfsr);
    qdr_word_u w;
    case (mode)
      MODE_ADDR:  w.word = {addr, ~addr};
      MODE_WALK1: w.word = 32'h1 << addr[4:0];
      MODE_LFSR:  w.word = lfsr;
      default:    w.word = {seed, seed};
    endcase
    return w;
  endfunction

  assign start_addr = ctrl_i.start_addr[QDR_ADDR_W-1:0];
  assign end_addr   = ctrl_i.end_addr[QDR_ADDR_W-1:0];
  assign last_addr  = (addr_q == end_addr);
  assign start_edge = ctrl_i.start & ~start_q;
  assign lfsr_seed  = {ctrl_i.seed, ~ctrl_i.seed};
  assign pattern    = gen_pattern(ctrl_i.mode, 16'(addr_q), ctrl_i.seed, lfsr_q);
  assign rd_issue   = (state_q == S_READ) && (count_q < (PTR_W+1)'(EXP_DEPTH));
  assign pop        = qdr_rd_valid_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q     <= S_IDLE;
      start_q     <= 1'b0;
      run_start_q <= 1'b0;
      wr_stb_q    <= 1'b0;
      rd_stb_q    <= 1'b0;
      count_q     <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
    end else begin
      start_q     <= ctrl_i.start;
      run_start_q <= 1'b0;
      wr_stb_q    <= 1'b0;
      rd_stb_q    <= 1'b0;
      count_q     <= count_q + {{PTR_W{1'b0}}, rd_issue} - {{PTR_W{1'b0}}, pop};
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case (state_q)
        S_IDLE: begin
          if (start_edge) begin  // Edges while busy are dropped
            state_q     <= S_WRITE;
            run_start_q <= 1'b1;
          end
        end
        S_WRITE: begin
          wr_stb_q <= 1'b1;
          if (last_addr)
            state_q <= S_READ;
        end
        S_READ: begin
          if (rd_issue) begin
            rd_stb_q <= 1'b1;
            wr_ptr_q <= wr_ptr_q + 1'b1;
            if (last_addr)
              state_q <= S_DRAIN;
          end
        end
        S_DRAIN: begin
          if (pop && count_q == (PTR_W+1)'(1))
            state_q <= S_FINISH;
        end
        default: state_q <= S_IDLE;  // Checkers latch the last compare here
      endcase
    end
  end

  // Address, pattern and expected-data path
  always_ff @(posedge wb_clk_i) begin
    case (state_q)
      S_IDLE: begin
        if (start_edge) begin
          addr_q <= start_addr;
          lfsr_q <= lfsr_seed;
        end
      end
      S_WRITE: begin
        wr_addr_q <= 16'(addr_q);
        wr_data_q <= pattern;
        if (last_addr) begin
          addr_q <= start_addr;
          lfsr_q <= lfsr_seed;  // Same sequence again for the read phase
        end else begin
          addr_q <= addr_q + 1'b1;
          lfsr_q <= lfsr_step(lfsr_q);
        end
      end
      S_READ: begin
        if (rd_issue) begin
          rd_addr_q              <= 16'(addr_q);
          exp_data_mem[wr_ptr_q] <= pattern;
          exp_addr_mem[wr_ptr_q] <= addr_q;
          addr_q                 <= addr_q + 1'b1;
          lfsr_q                 <= lfsr_step(lfsr_q);
        end
      end
      default: ;
    endcase
  end

  // Returned word against the queue head
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      cmp_o[i].valid    = qdr_rd_valid_i;
      cmp_o[i].addr     = 16'(exp_addr_mem[rd_ptr_q]);
      cmp_o[i].expected = exp_data_mem[rd_ptr_q].bytes[i];
      cmp_o[i].actual   = qdr_rd_data_i.bytes[i];
    end
  end

  assign qdr_wr_o    = '{strobe: wr_stb_q, addr: wr_addr_q, data: wr_data_q};
  assign qdr_rd_o    = '{strobe: rd_stb_q, addr: rd_addr_q};
  assign busy_o      = (state_q != S_IDLE);
  assign run_start_o = run_start_q;

endmodule

`default_nettype wire

//--- rtl/th_status_mux.sv
`timescale 1ns/1ns
`default_nettype none

module th_status_mux
  import th_regs_pkg::*;
  import qdr_pkg::*;
(
  input  logic                        wb_clk_i,
  input  logic                        wb_rst_i,
  input  logic                        run_start_i,
  input  logic                        busy_i,
  input  th_ctrl_t                    ctrl_i,
  input  logic [NUM_LANES-1:0][15:0]  lane_err_cnt_i,
  input  logic [NUM_LANES-1:0]        lane_mismatch_i,
  input  logic [NUM_LANES-1:0][15:0]  lane_first_addr_i,
  input  logic [NUM_LANES-1:0]        lane_first_valid_i,
  input  logic [20:0]                 status_addr_i,
  output logic [15:0]                 status_o
);

  logic                 ran_q;
  logic                 fail_seen_q;
  logic [15:0]          total_q;
  logic [15:0]          fail_addr_q;
  logic [NUM_LANES-1:0] fail_lanes_q;
  logic [NUM_LANES-1:0] hit;
  logic [15:0]          first_addr;
  logic                 done;
  logic                 pass;
  logic [15:0]          flags;

  assign hit  = lane_mismatch_i & ctrl_i.lane_mask;
  assign done = ran_q & ~busy_i;  // Rises as busy falls at the end of a run

  // Lowest failing lane gives the address
  always_comb begin
    first_addr = '0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (hit[i] && lane_first_valid_i[i])
        first_addr = lane_first_addr_i[i];
    end
  end

  always_comb begin
    pass = done;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (ctrl_i.lane_mask[i] && lane_err_cnt_i[i] != 16'h0)
        pass = 1'b0;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || run_start_i) begin
      ran_q        <= run_start_i;
      fail_seen_q  <= 1'b0;
      total_q      <= '0;
      fail_addr_q  <= '0;
      fail_lanes_q <= '0;
    end else begin
      if (|hit && total_q != 16'hffff)
        total_q <= total_q + 1'b1;
      if (|hit && !fail_seen_q) begin  // Earliest failing word only
        fail_seen_q  <= 1'b1;
        fail_addr_q  <= first_addr;
        fail_lanes_q <= hit;
      end
    end
  end

  always_comb begin
    flags              = '0;
    flags[ST_BUSY_BIT] = busy_i;
    flags[ST_DONE_BIT] = done;
    flags[ST_PASS_BIT] = pass;
  end

  always_comb begin
    case (status_addr_i)
      REG_ST_FLAGS:      status_o = flags;
      REG_ST_TOTAL:      status_o = total_q;
      REG_ST_LANE_0:     status_o = lane_err_cnt_i[0];
      REG_ST_LANE_1:     status_o = lane_err_cnt_i[1];
      REG_ST_LANE_2:     status_o = lane_err_cnt_i[2];
      REG_ST_LANE_3:     status_o = lane_err_cnt_i[3];
      REG_ST_FAIL_ADDR:  status_o = fail_addr_q;
      REG_ST_FAIL_LANES: status_o = 16'(fail_lanes_q);
      default:           status_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/th_top.sv
`timescale 1ns/1ns
`default_nettype none

module th_top
  import th_regs_pkg::*;
  import qdr_pkg::*;
#(
  parameter int QDR_ADDR_W = 16,
  parameter int EXP_DEPTH  = 8
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  output qdr_wr_t     qdr_wr_o,
  output qdr_rd_t     qdr_rd_o,
  input  logic        qdr_rd_valid_i,
  input  qdr_word_u   qdr_rd_data_i
);

  th_ctrl_t                   ctrl;
  logic [20:0]                status_addr;
  logic [15:0]                status_word;
  lane_cmp_t [NUM_LANES-1:0]  cmp;
  logic                       busy;
  logic                       run_start;
  logic [NUM_LANES-1:0][15:0] lane_err_cnt;
  logic [NUM_LANES-1:0][15:0] lane_first_addr;
  logic [NUM_LANES-1:0]       lane_mismatch;
  logic [NUM_LANES-1:0]       lane_first_valid;

  th_wb_regs th_wb_regs_i (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_sel_i     (wb_sel_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .ctrl_o       (ctrl),
    .status_addr_o(status_addr),
    .status_i     (status_word)
  );

  th_sequencer #(
    .QDR_ADDR_W(QDR_ADDR_W),
    .EXP_DEPTH (EXP_DEPTH)
  ) th_sequencer_i (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .ctrl_i        (ctrl),
    .qdr_rd_valid_i(qdr_rd_valid_i),
    .qdr_rd_data_i (qdr_rd_data_i),
    .qdr_wr_o      (qdr_wr_o),
    .qdr_rd_o      (qdr_rd_o),
    .cmp_o         (cmp),
    .busy_o        (busy),
    .run_start_o   (run_start)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    th_lane_check #(
      .QDR_ADDR_W(QDR_ADDR_W)
    ) th_lane_check_i (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .clear_i      (run_start),
      .cmp_i        (cmp[i]),
      .err_cnt_o    (lane_err_cnt[i]),
      .mismatch_o   (lane_mismatch[i]),
      .first_addr_o (lane_first_addr[i]),
      .first_valid_o(lane_first_valid[i])
    );
  end

  th_status_mux th_status_mux_i (
    .wb_clk_i          (wb_clk_i),
    .wb_rst_i          (wb_rst_i),
    .run_start_i       (run_start),
    .busy_i            (busy),
    .ctrl_i            (ctrl),
    .lane_err_cnt_i    (lane_err_cnt),
    .lane_mismatch_i   (lane_mismatch),
    .lane_first_addr_i (lane_first_addr),
    .lane_first_valid_i(lane_first_valid),
    .status_addr_i     (status_addr),
    .status_o          (status_word)
  );

endmodule

`default_nettype wire

//--- rtl/th_wb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module th_wb_regs
  import th_regs_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  output th_ctrl_t    ctrl_o,
  output logic [20:0] status_addr_o,
  input  logic [15:0] status_i
);

  localparam int NUM_CTRL = 5;

  logic [NUM_CTRL-1:0][15:0] ctrl_q;
  logic [20:0]               adr_q;
  logic                      ack_q;
  logic                      req;
  logic [NUM_CTRL-1:0]       wr_hit;
  logic [NUM_CTRL-1:0]       rd_hit;

  // One-hot control word select that is zero for status space
  function automatic logic [NUM_CTRL-1:0] ctrl_decode(input logic [20:0] adr);
    logic [NUM_CTRL-1:0] hit;
    hit[0] = (adr == REG_CTRL_0);
    hit[1] = (adr == REG_CTRL_1);
    hit[2] = (adr == REG_CTRL_2);
    hit[3] = (adr == REG_CTRL_3);
    hit[4] = (adr == REG_CTRL_4);
    return hit;
  endfunction

  assign req    = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_hit = ctrl_decode(wb_adr_i[21:1]);
  assign rd_hit = ctrl_decode(adr_q);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q  <= 1'b0;
      adr_q  <= '0;
      ctrl_q <= '0;
    end else begin
      ack_q <= req;  // Single cycle ack
      if (req) begin
        adr_q <= wb_adr_i[21:1];
        if (wb_we_i) begin
          for (int i = 0; i < NUM_CTRL; i++) begin
            if (wr_hit[i]) begin
              if (wb_sel_i[0])
                ctrl_q[i][7:0] <= wb_dat_i[7:0];
              if (wb_sel_i[1])
                ctrl_q[i][15:8] <= wb_dat_i[15:8];
            end
          end
        end
      end
    end
  end

  // Control words read back and everything else comes from the status block
  always_comb begin
    wb_dat_o = status_i;
    for (int i = 0; i < NUM_CTRL; i++) begin
      if (rd_hit[i])
        wb_dat_o = ctrl_q[i];
    end
  end

  assign wb_ack_o      = ack_q;
  assign ctrl_o        = th_ctrl_t'(ctrl_q);
  assign status_addr_o = adr_q;

endmodule

`default_nettype wire

//--- sim.f
rtl/th_regs_pkg.sv
rtl/qdr_pkg.sv
rtl/th_wb_regs.sv
rtl/th_sequencer.sv
rtl/th_lane_check.sv
rtl/th_status_mux.sv
rtl/th_top.sv
verif/qdr_mem_model.sv
verif/tb_th_top.sv

//--- verif/qdr_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module qdr_mem_model
  import qdr_pkg::*;
#(
  parameter int LATENCY = 3
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  qdr_wr_t     wr_i,
  input  qdr_rd_t     rd_i,
  input  logic        fault_en_i,
  input  logic [15:0] fault_addr_i,
  input  logic [4:0]  fault_bit_i,
  output logic        rd_valid_o,
  output qdr_word_u   rd_data_o
);

  logic [31:0]        mem [0:65535];
  logic [LATENCY-1:0] valid_q;
  logic [31:0]        data_q [LATENCY];
  logic [31:0]        flip_mask;

  // Every word starts with a value of its own, so a missing write shows up
  initial begin
    for (int a = 0; a < 65536; a++)
      mem[a] = 32'(a) * 32'h9e37_79b1 ^ 32'h0f0f_3c3c;
  end

  assign flip_mask = (fault_en_i && rd_i.addr == fault_addr_i) ? (32'h1 << fault_bit_i) : 32'h0;

  always @(posedge wb_clk_i) begin
    if (wr_i.strobe)
      mem[wr_i.addr] <= wr_i.data.word;
    if (wb_rst_i)
      valid_q <= '0;
    else
      valid_q <= {valid_q[LATENCY-2:0], rd_i.strobe};
    data_q[0] <= mem[rd_i.addr] ^ flip_mask;  // Fault flips one bit on the way out
    for (int i = 1; i < LATENCY; i++)
      data_q[i] <= data_q[i-1];
  end

  assign rd_valid_o = valid_q[LATENCY-1];
  assign rd_data_o  = data_q[LATENCY-1];

endmodule

`default_nettype wire

//--- verif/tb_th_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_th_top
  import th_regs_pkg::*;
  import qdr_pkg::*;
();

  localparam int CLK_HALF    = 5;
  localparam int BUS_TIMEOUT = 20;   // Cycles to wait for ack
  localparam int RUN_POLLS   = 500;  // Status reads to wait for done
  localparam logic [15:0] FLAGS_PASS = (16'h1 << ST_DONE_BIT) | (16'h1 << ST_PASS_BIT);
  localparam logic [15:0] FLAGS_FAIL = (16'h1 << ST_DONE_BIT);

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic [1:0]  wb_sel_i;
  logic [31:0] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  qdr_wr_t     qdr_wr;
  qdr_rd_t     qdr_rd;
  logic        qdr_rd_valid;
  qdr_word_u   qdr_rd_data;
  logic        fault_en;
  logic [15:0] fault_addr;
  logic [4:0]  fault_bit;

  int          error_count;
  int          tests_run;
  int          tests_failed;
  logic [15:0] ctrl_mirror [5];
  logic [15:0] wr_seen_addr [$];
  logic [31:0] wr_seen_data [$];
  logic [15:0] rd_seen_addr [$];

  th_top #(
    .QDR_ADDR_W(16),
    .EXP_DEPTH (8)
  ) th_top_i (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_we_i       (wb_we_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_sel_i      (wb_sel_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .qdr_wr_o      (qdr_wr),
    .qdr_rd_o      (qdr_rd),
    .qdr_rd_valid_i(qdr_rd_valid),
    .qdr_rd_data_i (qdr_rd_data)
  );

  qdr_mem_model #(
    .LATENCY(3)
  ) mem_model_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wr_i        (qdr_wr),
    .rd_i        (qdr_rd),
    .fault_en_i  (fault_en),
    .fault_addr_i(fault_addr),
    .fault_bit_i (fault_bit),
    .rd_valid_o  (qdr_rd_valid),
    .rd_data_o   (qdr_rd_data)
  );

  always #CLK_HALF wb_clk_i = ~wb_clk_i;

  // Log every write and read strobe the memory sees
  always @(negedge wb_clk_i) begin
    if (qdr_wr.strobe) begin
      wr_seen_addr.push_back(qdr_wr.addr);
      wr_seen_data.push_back(qdr_wr.data.word);
    end
    if (qdr_rd.strobe)
      rd_seen_addr.push_back(qdr_rd.addr);
  end

  function automatic logic [31:0] ref_lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h8020_0003;
    return n;
  endfunction

  function automatic logic [31:0] ref_pattern(input th_mode_e mode, input logic [15:0] addr,
                                              input logic [15:0] seed, input logic [31:0] lfsr);
    logic [31:0] w;
    w = '0;
    case (mode)
      MODE_ADDR: begin
        w[31:16] = addr;
        w[15:0]  = addr ^ 16'hffff;
      end
      MODE_WALK1: w[addr % 32] = 1'b1;
      MODE_LFSR:  w = lfsr;
      default:    w = {seed, seed};
    endcase
    return w;
  endfunction

  function automatic logic [15:0] merge_bytes(input logic [15:0] old_v, input logic [15:0] new_v,
                                              input logic [1:0] sel);
    logic [15:0] m;
    m = old_v;
    if (sel[0])
      m[7:0] = new_v[7:0];
    if (sel[1])
      m[15:8] = new_v[15:8];
    return m;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %0t: %s = %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic wb_write(input logic [20:0] word_addr, input logic [1:0] sel,
                          input logic [15:0] data);
    int   n;
    logic got;
    got = 1'b0;
    n = 0;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_sel_i <= sel;
    wb_adr_i <= {10'h0, word_addr, 1'b0};
    wb_dat_i <= data;
    while (!got && n < BUS_TIMEOUT) begin
      @(negedge wb_clk_i);
      got = wb_ack_o;
      n++;
    end
    if (!got) begin
      $display("Bus write to word %0d got no ack within %0d cycles", word_addr, BUS_TIMEOUT);
      error_count++;
    end
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_read(input logic [20:0] word_addr, output logic [15:0] data);
    int   n;
    logic got;
    got = 1'b0;
    n = 0;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_sel_i <= 2'b11;
    wb_adr_i <= {10'h0, word_addr, 1'b0};
    while (!got && n < BUS_TIMEOUT) begin
      @(negedge wb_clk_i);
      got = wb_ack_o;
      n++;
    end
    data = wb_dat_o;  // Valid while ack is high
    if (!got) begin
      $display("Bus read of word %0d got no ack within %0d cycles", word_addr, BUS_TIMEOUT);
      error_count++;
    end
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [20:0] word_addr,
                             input logic [15:0] exp);
    logic [15:0] data;
    wb_read(word_addr, data);
    check_value(name, 32'(data), 32'(exp));
  endtask

  task automatic write_mirror(input int r, input logic [1:0] sel, input logic [15:0] data);
    wb_write(21'(r), sel, data);
    ctrl_mirror[r] = merge_bytes(ctrl_mirror[r], data, sel);
  endtask

  task automatic set_fault(input logic en, input logic [15:0] addr, input logic [4:0] bit_pos);
    @(posedge wb_clk_i);
    fault_en   <= en;
    fault_addr <= addr;
    fault_bit  <= bit_pos;
  endtask

  task automatic run_and_wait(input th_mode_e mode, input logic [15:0] seed,
                              input logic [15:0] start_addr, input logic [15:0] end_addr,
                              input logic [3:0] mask);
    logic [15:0] flags;
    logic        done;
    int          n;
    done = 1'b0;
    n = 0;
    wb_write(REG_CTRL_1, 2'b11, seed);
    wb_write(REG_CTRL_2, 2'b11, start_addr);
    wb_write(REG_CTRL_3, 2'b11, end_addr);
    wb_write(REG_CTRL_4, 2'b11, {12'h0, mask});
    wr_seen_addr.delete();
    wr_seen_data.delete();
    rd_seen_addr.delete();
    wb_write(REG_CTRL_0, 2'b11, {13'h0, mode, 1'b1});
    while (!done && n < RUN_POLLS) begin
      wb_read(REG_ST_FLAGS, flags);
      done = flags[ST_DONE_BIT];
      n++;
    end
    if (!done) begin
      $display("Run in mode %0d did not finish within %0d status reads", mode, RUN_POLLS);
      error_count++;
    end
    wb_write(REG_CTRL_0, 2'b11, {13'h0, mode, 1'b0});  // Start low again for the next edge
  endtask

  task automatic check_writes(input th_mode_e mode, input logic [15:0] seed,
                              input logic [15:0] start_addr, input logic [15:0] end_addr);
    int          count;
    logic [31:0] lfsr;
    logic [15:0] addr;
    count = int'(end_addr) - int'(start_addr) + 1;
    lfsr = {seed, ~seed};
    check_value("write count", 32'(wr_seen_addr.size()), 32'(count));
    for (int i = 0; i < count && i < wr_seen_addr.size(); i++) begin
      addr = start_addr + 16'(i);
      check_value($sformatf("write address %0d", i), 32'(wr_seen_addr[i]), 32'(addr));
      check_value($sformatf("write data at %0d", addr), wr_seen_data[i],
                  ref_pattern(mode, addr, seed, lfsr));
      lfsr = ref_lfsr_next(lfsr);
    end
  endtask

  task automatic check_reads(input logic [15:0] start_addr, input logic [15:0] end_addr);
    int          count;
    logic [15:0] addr;
    count = int'(end_addr) - int'(start_addr) + 1;
    check_value("read count", 32'(rd_seen_addr.size()), 32'(count));
    for (int i = 0; i < count && i < rd_seen_addr.size(); i++) begin
      addr = start_addr + 16'(i);
      check_value($sformatf("read address %0d", i), 32'(rd_seen_addr[i]), 32'(addr));
    end
  endtask

  task automatic check_results(input logic [15:0] exp_flags, input logic [15:0] exp_total,
                               input logic [NUM_LANES-1:0][15:0] exp_lane,
                               input logic [15:0] exp_fail_addr,
                               input logic [NUM_LANES-1:0] exp_fail_lanes);
    read_expect("status flags", REG_ST_FLAGS, exp_flags);
    read_expect("total errors", REG_ST_TOTAL, exp_total);
    for (int i = 0; i < NUM_LANES; i++)
      read_expect($sformatf("lane %0d errors", i), REG_ST_LANE_0 + 21'(i), exp_lane[i]);
    read_expect("first fail address", REG_ST_FAIL_ADDR, exp_fail_addr);
    read_expect("fail lanes", REG_ST_FAIL_LANES, 16'(exp_fail_lanes));
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic test_reset_values();
    int e0;
    e0 = error_count;
    for (int r = 0; r < 5; r++)
      read_expect($sformatf("ctrl word %0d", r), 21'(r), 16'h0);
    read_expect("status flags", REG_ST_FLAGS, 16'h0);
    finish_test("reset_values", e0);
  endtask

  task automatic test_byte_writes();
    int          e0;
    logic [15:0] v;
    e0 = error_count;
    for (int r = 0; r < 5; r++)
      ctrl_mirror[r] = 16'h0;
    // Low bytes stay even so CTRL_0 never starts a run
    for (int r = 0; r < 5; r++) begin
      v = 16'h3c5a + 16'(r) * 16'h1102;
      write_mirror(r, 2'b11, v);
      write_mirror(r, 2'b01, v ^ 16'hf0f0);
      read_expect($sformatf("ctrl word %0d low byte", r), 21'(r), ctrl_mirror[r]);
      write_mirror(r, 2'b10, v ^ 16'h0f0f);
      read_expect($sformatf("ctrl word %0d high byte", r), 21'(r), ctrl_mirror[r]);
    end
    for (int r = 0; r < 5; r++)
      read_expect($sformatf("ctrl word %0d final", r), 21'(r), ctrl_mirror[r]);
    for (int r = 0; r < 5; r++)
      wb_write(21'(r), 2'b11, 16'h0);
    finish_test("byte_writes", e0);
  endtask

  task automatic test_addr_run();
    int e0;
    e0 = error_count;
    run_and_wait(MODE_ADDR, 16'h0, 16'd16, 16'd47, 4'hf);
    check_writes(MODE_ADDR, 16'h0, 16'd16, 16'd47);
    check_reads(16'd16, 16'd47);
    check_results(FLAGS_PASS, 16'h0, '0, 16'h0, 4'h0);
    finish_test("addr_run", e0);
  endtask

  task automatic test_lfsr_walk_runs();
    int e0;
    e0 = error_count;
    run_and_wait(MODE_LFSR, 16'h1a1c, 16'd100, 16'd163, 4'hf);
    check_writes(MODE_LFSR, 16'h1a1c, 16'd100, 16'd163);
    check_reads(16'd100, 16'd163);
    check_results(FLAGS_PASS, 16'h0, '0, 16'h0, 4'h0);
    run_and_wait(MODE_WALK1, 16'h1a1c, 16'd40, 16'd79, 4'hf);
    check_writes(MODE_WALK1, 16'h1a1c, 16'd40, 16'd79);
    check_reads(16'd40, 16'd79);
    check_results(FLAGS_PASS, 16'h0, '0, 16'h0, 4'h0);
    finish_test("lfsr_walk_runs", e0);
  endtask

  task automatic test_fault_detect();
    int e0;
    e0 = error_count;
    set_fault(1'b1, 16'd7, 5'd19);  // Bit 19 sits in lane 2
    run_and_wait(MODE_ADDR, 16'h0, 16'd0, 16'd31, 4'hf);
    check_results(FLAGS_FAIL, 16'h1, {16'h0, 16'h1, 16'h0, 16'h0}, 16'd7, 4'b0100);
    finish_test("fault_detect", e0);
  endtask

  task automatic test_fault_masked();
    int e0;
    e0 = error_count;
    run_and_wait(MODE_ADDR, 16'h0, 16'd0, 16'd31, 4'b1011);
    // Lane 2 still counts, but it is left out of total and pass
    check_results(FLAGS_PASS, 16'h0, {16'h0, 16'h1, 16'h0, 16'h0}, 16'h0, 4'h0);
    set_fault(1'b0, 16'h0, 5'd0);
    finish_test("fault_masked", e0);
  endtask

  initial begin
    wb_clk_i     = 1'b0;
    wb_rst_i     = 1'b1;
    wb_we_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_sel_i     = 2'b00;
    wb_adr_i     = 32'h0;
    wb_dat_i     = 16'h0;
    fault_en     = 1'b0;
    fault_addr   = 16'h0;
    fault_bit    = 5'd0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (2) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    test_reset_values();
    test_byte_writes();
    test_addr_run();
    test_lfsr_walk_runs();
    test_fault_detect();
    test_fault_masked();

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
